/* design/usb_pkg.sv */
package usb_pkg;

   // 4-bit packet ids, the check nibble is added on the wire
   typedef enum logic [3:0]
   {
      RESERVED = 4'b0000,
      OUT      = 4'b0001,  // token
      ACK      = 4'b0010,  // handshake
      DATA0    = 4'b0011,  // data, even toggle
      IN       = 4'b1001,  // token, not served here
      NAK      = 4'b1010,  // handshake
      DATA1    = 4'b1011,  // data, odd toggle
      SETUP    = 4'b1101   // token, endpoint 0 only
   } pid_t;

   // token body after the pid, 16 bits sent lsb first
   typedef union packed
   {
      logic [1:0][7:0] bytes;  // bytes[0] is the first byte on the bus
      struct packed
      {
         logic [4:0] crc5;  // top five bits of byte 1
         logic [3:0] endp;  // straddles both bytes
         logic [6:0] addr;  // low seven bits of byte 0
      } f;
   } token_word_t;

   // reflected polynomials since the bus is lsb first
   localparam logic [4:0]  CRC5_POLY      = 5'b10100;           // x^5+x^2+1
   localparam logic [4:0]  CRC5_SEED      = 5'b11111;
   localparam logic [4:0]  CRC5_RESIDUAL  = 5'b00110;           // 01100 reversed
   localparam logic [15:0] CRC16_POLY     = 16'ha001;           // x^16+x^15+x^2+1
   localparam logic [15:0] CRC16_SEED     = 16'hffff;
   localparam logic [15:0] CRC16_RESIDUAL = 16'hb001;           // 800d reversed

   // one bit of crc5
   function automatic logic [4:0] crc5_step(input logic [4:0] crc, input logic d);
      logic [4:0] c;
      c = crc >> 1;
      if (crc[0] ^ d)
         c = c ^ CRC5_POLY;
      return c;
   endfunction

   // one byte of crc16, bit 0 goes first
   function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] d);
      logic [15:0] c;
      c = crc;
      for (int i = 0; i < 8; i++)
      begin
         if (c[0] ^ d[i])
            c = (c >> 1) ^ CRC16_POLY;
         else
            c = c >> 1;
      end
      return c;
   endfunction

endpackage

/* design/usb_rx_decoder.sv */
`timescale 1ns/10ps

module usb_rx_decoder
   import usb_pkg::*;
   (
      input  logic        clk,
      input  logic        reset,
      input  logic [7:0]  rx_data,         // byte from transceiver
      input  logic        rx_active,       // high for the whole packet
      input  logic        rx_valid,        // one pulse per byte
      input  logic        rx_error,        // bit stuff or similar fault
      output logic        tok_valid,       // good token, one cycle
      output pid_t        tok_pid,
      output token_word_t tok_word,
      output logic        dat_start,       // data pid seen
      output pid_t        dat_pid,
      output logic [7:0]  dat_byte,
      output logic        dat_byte_valid,  // includes the crc16 bytes
      output logic        dat_end,
      output logic        dat_abort        // rx_error ended the packet
   );

   localparam logic [2:0] S_IDLE  = 3'd0;  // waiting for a pid byte
   localparam logic [2:0] S_TOK0  = 3'd1;
   localparam logic [2:0] S_TOK1  = 3'd2;
   localparam logic [2:0] S_CHECK = 3'd3;  // crc5 over the captured word
   localparam logic [2:0] S_DATA  = 3'd4;
   localparam logic [2:0] S_SKIP  = 3'd5;  // drain until rx_active drops

   logic [2:0] state;
   pid_t       rx_pid;
   logic       pid_ok;
   logic [4:0] crc5;
   logic       crc5_ok;

   assign rx_pid = pid_t'(rx_data[3:0]);
   assign pid_ok = (rx_data[7:4] == ~rx_data[3:0]);  // check nibble

   // residual over all 16 token bits, crc included
   always_comb
   begin
      crc5 = CRC5_SEED;
      for (int b = 0; b < 2; b++)
         for (int k = 0; k < 8; k++)
            crc5 = crc5_step(crc5, tok_word.bytes[b][k]);
      crc5_ok = (crc5 == CRC5_RESIDUAL);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state          <= S_IDLE;
         tok_valid      <= 1'b0;
         dat_start      <= 1'b0;
         dat_byte_valid <= 1'b0;
         dat_end        <= 1'b0;
         dat_abort      <= 1'b0;
      end
      else
      begin
         tok_valid      <= 1'b0;  // all strobes are single cycle
         dat_start      <= 1'b0;
         dat_byte_valid <= 1'b0;
         dat_end        <= 1'b0;
         dat_abort      <= 1'b0;
         case (state)
            S_IDLE:
               if (rx_active && rx_error)
                  state <= S_SKIP;
               else if (rx_active && rx_valid)
               begin
                  if (!pid_ok)
                     state <= S_SKIP;                 // corrupted pid, drop packet
                  else
                  begin
                     case (rx_pid)
                        OUT, IN, SETUP:
                        begin
                           tok_pid <= rx_pid;
                           state   <= S_TOK0;
                        end
                        DATA0, DATA1:
                        begin
                           dat_pid   <= rx_pid;
                           dat_start <= 1'b1;
                           state     <= S_DATA;
                        end
                        default:
                           state <= S_SKIP;         // handshakes etc. not for us
                     endcase
                  end
               end
            S_TOK0:
               if (rx_error)
                  state <= S_SKIP;
               else if (!rx_active)
                  state <= S_IDLE;                    // truncated token
               else if (rx_valid)
               begin
                  tok_word.bytes[0] <= rx_data;       // addr + endp[0]
                  state             <= S_TOK1;
               end
            S_TOK1:
               if (rx_error)
                  state <= S_SKIP;
               else if (!rx_active)
                  state <= S_IDLE;
               else if (rx_valid)
               begin
                  tok_word.bytes[1] <= rx_data;       // endp[3:1] + crc5
                  state             <= S_CHECK;
               end
            S_CHECK:
            begin
               tok_valid <= crc5_ok;                   // bad crc5 just vanishes
               state     <= S_SKIP;
            end
            S_DATA:
               if (rx_error)
               begin
                  dat_end   <= 1'b1;
                  dat_abort <= 1'b1;
                  state     <= S_SKIP;
               end
               else if (!rx_active)
               begin
                  dat_end <= 1'b1;                    // eop
                  state   <= S_IDLE;
               end
               else if (rx_valid)
               begin
                  dat_byte       <= rx_data;
                  dat_byte_valid <= 1'b1;
               end
            default:
               if (!rx_active)
                  state <= S_IDLE;
         endcase
      end
   end

endmodule

/* design/usb_crc16_check.sv */
`timescale 1ns/10ps

module usb_crc16_check
   import usb_pkg::*;
   (
      input  logic       clk,
      input  logic       reset,
      input  logic       dat_start,       // restart on each data pid
      input  logic [7:0] dat_byte,
      input  logic       dat_byte_valid,  // payload and both crc bytes
      input  logic       dat_end,
      output logic       crc_ok           // valid from the cycle after dat_end
   );

   logic [15:0] crc;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         crc    <= CRC16_SEED;
         crc_ok <= 1'b0;
      end
      else
      begin
         if (dat_start)
         begin
            crc    <= CRC16_SEED;
            crc_ok <= 1'b0;                      // stale result cleared
         end
         else if (dat_byte_valid)
            crc <= crc16_step(crc, dat_byte);    // running over crc bytes too

         // fixed residual once the transmitted crc is folded in
         if (dat_end)
            crc_ok <= (crc == CRC16_RESIDUAL);
      end
   end

endmodule

/* design/usb_transaction_ctrl.sv */
`timescale 1ns/10ps

module usb_transaction_ctrl
   import usb_pkg::*;
   #(parameter int num_endp = 3)
   (
      input  logic        clk,
      input  logic        reset,
      input  logic [6:0]  device_addr,
      input  logic        tok_valid,
      input  pid_t        tok_pid,
      input  token_word_t tok_word,
      input  logic        dat_start,
      input  pid_t        dat_pid,
      input  logic [7:0]  dat_byte,
      input  logic        dat_byte_valid,
      input  logic        dat_end,
      input  logic        dat_abort,
      input  logic        crc_ok,
      output logic [7:0]  ep_data [num_endp],
      output logic        ep_valid [num_endp],
      output logic        ep_end [num_endp],
      output logic        ep_crc_ok [num_endp],
      input  logic        ep_ready [num_endp],
      output logic        reply_valid,
      output pid_t        reply_pid,
      input  logic        reply_ready
   );

   localparam logic [2:0] S_IDLE  = 3'd0;
   localparam logic [2:0] S_WAIT  = 3'd1;  // token taken, data pid expected
   localparam logic [2:0] S_DATA  = 3'd2;
   localparam logic [2:0] S_END   = 3'd3;  // crc_ok settles here
   localparam logic [2:0] S_REPLY = 3'd4;

   logic [2:0] state;
   pid_t       tok_pid_q;
   logic [3:0] endp_q;
   logic [7:0] hold0;       // newest byte
   logic [7:0] hold1;       // byte before it
   logic [1:0] fill;        // delay line occupancy, saturates at 2
   logic [7:0] out_byte;
   logic       out_valid;
   logic       out_end;
   logic       out_crc_ok;
   logic       nak_seen;    // some byte met a busy endpoint
   logic       abort_q;
   logic       tok_accept;
   logic       pid_fits;
   logic       sel_ready;

   always_comb
   begin
      tok_accept = 1'b0;
      if (tok_valid && tok_word.f.addr == device_addr && int'(tok_word.f.endp) < num_endp)
      begin
         if (tok_pid == OUT)
            tok_accept = 1'b1;
         else if (tok_pid == SETUP && tok_word.f.endp == 4'd0)
            tok_accept = 1'b1;                 // control endpoint only
      end
   end

   // setup needs data0, out takes either toggle
   assign pid_fits = (dat_pid == DATA0) || (dat_pid == DATA1 && tok_pid_q == OUT);

   always_comb
   begin
      sel_ready = 1'b1;
      for (int i = 0; i < num_endp; i++)
      begin
         ep_data[i]   = out_byte;              // shared bus, strobes select
         ep_valid[i]  = out_valid && (endp_q == 4'(i));
         ep_end[i]    = out_end && (endp_q == 4'(i));
         ep_crc_ok[i] = out_end && out_crc_ok && (endp_q == 4'(i));
         if (endp_q == 4'(i))
            sel_ready = ep_ready[i];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= S_IDLE;
         out_valid   <= 1'b0;
         out_end     <= 1'b0;
         reply_valid <= 1'b0;
         fill        <= 2'd0;
         nak_seen    <= 1'b0;
         abort_q     <= 1'b0;
      end
      else
      begin
         out_valid <= 1'b0;
         out_end   <= 1'b0;
         case (state)
            S_IDLE, S_WAIT:
               if (tok_accept)
               begin
                  tok_pid_q <= tok_pid;
                  endp_q    <= tok_word.f.endp;
                  state     <= S_WAIT;               // a newer token replaces the old one
               end
               else if (state == S_WAIT && dat_start)
               begin
                  fill     <= 2'd0;
                  nak_seen <= 1'b0;
                  abort_q  <= 1'b0;
                  state    <= pid_fits ? S_DATA : S_IDLE;
               end
            S_DATA:
            begin
               if (dat_byte_valid)
               begin
                  hold0 <= dat_byte;
                  hold1 <= hold0;
                  if (fill == 2'd2)
                  begin
                     out_byte  <= hold1;             // two bytes behind, crc never leaves
                     out_valid <= 1'b1;
                  end
                  else
                     fill <= fill + 2'd1;
               end
               if (out_valid && !sel_ready)
                  nak_seen <= 1'b1;                 // byte still shown, reply becomes nak
               if (dat_end)
               begin
                  abort_q <= dat_abort;
                  state   <= S_END;
               end
            end
            S_END:
            begin
               out_end    <= 1'b1;
               out_crc_ok <= crc_ok && !abort_q;
               if (crc_ok && !abort_q)
               begin
                  reply_valid <= 1'b1;               // rises with ep_end
                  reply_pid   <= nak_seen ? NAK : ACK;
                  state       <= S_REPLY;
               end
               else
                  state <= S_IDLE;                   // corrupt data, stay silent
            end
            S_REPLY:
               if (reply_ready)
               begin
                  reply_valid <= 1'b0;
                  state       <= S_IDLE;
               end
            default:
               state <= S_IDLE;
         endcase
      end
   end

endmodule

/* design/usb_handshake_tx.sv */
`timescale 1ns/10ps

module usb_handshake_tx
   import usb_pkg::*;
   (
      input  logic       clk,
      input  logic       reset,
      input  logic       reply_valid,
      input  pid_t       reply_pid,   // ack or nak
      output logic       reply_ready,
      output logic [7:0] tx_data,     // pid with check nibble on top
      output logic       tx_valid,
      input  logic       tx_ready     // transceiver took the byte
   );

   logic [3:0] pid_bits;
   logic       take;

   assign pid_bits    = reply_pid;
   assign reply_ready = !tx_valid;                // single entry, free when idle
   assign take        = reply_valid && reply_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
         tx_valid <= 1'b0;
      else if (take)
         tx_valid <= 1'b1;
      else if (tx_ready)
         tx_valid <= 1'b0;                         // dropped only after acceptance
   end

   // byte register, frozen while tx_valid is up
   always_ff @(posedge clk)
   begin
      if (take)
         tx_data <= {~pid_bits, pid_bits};
   end

endmodule

/* design/usb_sie_top.sv */
`timescale 1ns/10ps

module usb_sie_top
   import usb_pkg::*;
   #(parameter int num_endp = 3)   // 1..3 for a low-speed device
   (
      input  logic       clk,
      input  logic       reset,
      input  logic [7:0] rx_data,
      input  logic       rx_active,
      input  logic       rx_valid,
      input  logic       rx_error,
      output logic [7:0] tx_data,
      output logic       tx_valid,
      input  logic       tx_ready,
      input  logic [6:0] device_addr,
      output logic [7:0] ep_data [num_endp],
      output logic       ep_valid [num_endp],
      output logic       ep_end [num_endp],
      output logic       ep_crc_ok [num_endp],
      input  logic       ep_ready [num_endp]
   );

   // decoder outputs
   logic        tok_valid;
   pid_t        tok_pid;
   token_word_t tok_word;
   logic        dat_start;
   pid_t        dat_pid;
   logic [7:0]  dat_byte;
   logic        dat_byte_valid;
   logic        dat_end;
   logic        dat_abort;

   logic        crc_ok;

   // controller to transmitter
   logic        reply_valid;
   pid_t        reply_pid;
   logic        reply_ready;

   usb_rx_decoder u_rx_decoder
   (
      .clk            (clk),
      .reset          (reset),
      .rx_data        (rx_data),
      .rx_active      (rx_active),
      .rx_valid       (rx_valid),
      .rx_error       (rx_error),
      .tok_valid      (tok_valid),
      .tok_pid        (tok_pid),
      .tok_word       (tok_word),
      .dat_start      (dat_start),
      .dat_pid        (dat_pid),
      .dat_byte       (dat_byte),
      .dat_byte_valid (dat_byte_valid),
      .dat_end        (dat_end),
      .dat_abort      (dat_abort)
   );

   usb_crc16_check u_crc16_check
   (
      .clk            (clk),
      .reset          (reset),
      .dat_start      (dat_start),
      .dat_byte       (dat_byte),
      .dat_byte_valid (dat_byte_valid),
      .dat_end        (dat_end),
      .crc_ok         (crc_ok)
   );

   usb_transaction_ctrl #(.num_endp(num_endp)) u_transaction_ctrl
   (
      .clk            (clk),
      .reset          (reset),
      .device_addr    (device_addr),
      .tok_valid      (tok_valid),
      .tok_pid        (tok_pid),
      .tok_word       (tok_word),
      .dat_start      (dat_start),
      .dat_pid        (dat_pid),
      .dat_byte       (dat_byte),
      .dat_byte_valid (dat_byte_valid),
      .dat_end        (dat_end),
      .dat_abort      (dat_abort),
      .crc_ok         (crc_ok),
      .ep_data        (ep_data),
      .ep_valid       (ep_valid),
      .ep_end         (ep_end),
      .ep_crc_ok      (ep_crc_ok),
      .ep_ready       (ep_ready),
      .reply_valid    (reply_valid),
      .reply_pid      (reply_pid),
      .reply_ready    (reply_ready)
   );

   usb_handshake_tx u_handshake_tx
   (
      .clk            (clk),
      .reset          (reset),
      .reply_valid    (reply_valid),
      .reply_pid      (reply_pid),
      .reply_ready    (reply_ready),
      .tx_data        (tx_data),
      .tx_valid       (tx_valid),
      .tx_ready       (tx_ready)
   );

endmodule

/* test/usb_sie_tb.sv */
`timescale 1ns/10ps

module usb_sie_tb;

   localparam int num_endp  = 3;
   localparam int max_cases = 64;
   localparam logic [6:0] dev_addr = 7'h2a;

   logic       clk = 1'b0;
   logic       reset;
   logic [7:0] rx_data;
   logic       rx_active;
   logic       rx_valid;
   logic       rx_error;
   logic [7:0] tx_data;
   logic       tx_valid;
   logic       tx_ready = 1'b0;
   logic [6:0] device_addr;
   logic [7:0] ep_data [num_endp];
   logic       ep_valid [num_endp];
   logic       ep_end [num_endp];
   logic       ep_crc_ok [num_endp];
   logic       ep_ready [num_endp];

   // case table, one row per transaction
   logic [3:0] c_tok [max_cases];
   logic [6:0] c_addr [max_cases];
   int         c_endp [max_cases];
   logic [7:0] c_dpid [max_cases];     // whole byte, check nibble included
   int         c_len [max_cases];
   int         c_f5 [max_cases];
   int         c_f16 [max_cases];
   int         c_ferr [max_cases];
   logic [2:0] c_nrdy [max_cases];     // bit i set: endpoint i busy
   int         c_xdat [max_cases];     // 0 silent, 1 payload good, 2 crc_ok low
   logic [7:0] c_xrep [max_cases];     // expected handshake byte, 0 none
   int         n_cases = 0;
   logic       cases_loaded = 1'b0;

   logic [15:0] lfsr = 16'd99;
   logic [7:0]  pkt [24];             // bytes of the packet on the wire
   logic [7:0]  sent [16];            // payload for comparison
   logic [7:0]  got [num_endp][64];   // bytes seen per endpoint
   int          got_cnt [num_endp];
   int          end_cnt [num_endp];
   int          ok_cnt [num_endp];
   int          tx_count = 0;
   logic [7:0]  tx_last = 8'h00;
   logic [1:0]  tx_wait = 2'd0;
   logic        held = 1'b0;
   logic [7:0]  held_data = 8'h00;
   int          err_data = 0;
   int          err_reply = 0;
   int          err_other = 0;

   usb_sie_top #(.num_endp(num_endp)) u_dut
   (
      .clk         (clk),
      .reset       (reset),
      .rx_data     (rx_data),
      .rx_active   (rx_active),
      .rx_valid    (rx_valid),
      .rx_error    (rx_error),
      .tx_data     (tx_data),
      .tx_valid    (tx_valid),
      .tx_ready    (tx_ready),
      .device_addr (device_addr),
      .ep_data     (ep_data),
      .ep_valid    (ep_valid),
      .ep_end      (ep_end),
      .ep_crc_ok   (ep_crc_ok),
      .ep_ready    (ep_ready)
   );

   always #2 clk = ~clk;  // 4 ns period

   // galois lfsr, one step per bit taken
   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         v = (v << 1) | int'(lfsr[0]);
         if (lfsr[0])
            lfsr = (lfsr >> 1) ^ 16'hb400;
         else
            lfsr = lfsr >> 1;
      end
      return v;
   endfunction

   // usb crc5 over addr and endp, sent inverted
   function automatic logic [4:0] token_crc5(input logic [10:0] bits);
      logic [4:0] c;
      logic       fb;
      c = 5'h1f;
      for (int i = 0; i < 11; i++)
      begin
         fb = c[0] ^ bits[i];
         c  = c >> 1;
         if (fb)
            c = c ^ 5'h14;
      end
      return ~c;
   endfunction

   function automatic logic [15:0] data_crc16(input logic [15:0] c, input logic [7:0] d);
      logic [15:0] r;
      logic        fb;
      r = c;
      for (int i = 0; i < 8; i++)
      begin
         fb = r[0] ^ d[i];
         r  = r >> 1;
         if (fb)
            r = r ^ 16'ha001;
      end
      return r;
   endfunction

   // one byte with a random idle gap before it
   task automatic send_byte(input logic [7:0] b);
      int gap;
      gap = rand_bits(2);
      repeat (gap) @(posedge clk);
      @(posedge clk);
      rx_data  <= b;
      rx_valid <= 1'b1;
      @(posedge clk);
      rx_valid <= 1'b0;
   endtask

   // err_after < 0 means a clean packet
   task automatic send_packet(input int n, input int err_after);
      @(posedge clk);
      rx_active <= 1'b1;
      for (int i = 0; i < n; i++)
      begin
         if (i == err_after)
         begin
            @(posedge clk);
            rx_error <= 1'b1;
            @(posedge clk);
            rx_error <= 1'b0;
            break;
         end
         send_byte(pkt[i]);
      end
      @(posedge clk);
      rx_active <= 1'b0;  // eop
      repeat (3) @(posedge clk);
   endtask

   task automatic load_cases();
      int          fd;
      int          r;
      logic [8*128-1:0] line_buf;
      fd = $fopen("test/usb_sie_cases.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the case file test/usb_sie_cases.txt");
         err_other++;
      end
      else
      begin
         while (!$feof(fd) && n_cases < max_cases)
         begin
            r = $fgets(line_buf, fd);
            if (r > 0 && $sscanf(line_buf, "%h %h %d %h %d %d %d %d %b %d %h",
                  c_tok[n_cases], c_addr[n_cases], c_endp[n_cases], c_dpid[n_cases],
                  c_len[n_cases], c_f5[n_cases], c_f16[n_cases], c_ferr[n_cases],
                  c_nrdy[n_cases], c_xdat[n_cases], c_xrep[n_cases]) == 11)
               n_cases++;   // comment lines fail the scan
         end
         $fclose(fd);
      end
   endtask

   // endpoint model, records everything it sees
   always @(posedge clk)
   begin
      for (int i = 0; i < num_endp; i++)
      begin
         if (ep_valid[i])
         begin
            if (got_cnt[i] < 64)
               got[i][got_cnt[i]] = ep_data[i];
            got_cnt[i] = got_cnt[i] + 1;
         end
         if (ep_end[i])
            end_cnt[i] = end_cnt[i] + 1;
         if (ep_end[i] && ep_crc_ok[i])
            ok_cnt[i] = ok_cnt[i] + 1;
      end
   end

   // transmitter model with a slow, random tx_ready
   always @(posedge clk)
   begin
      if (tx_valid && tx_ready)
      begin
         tx_count <= tx_count + 1;
         tx_last  <= tx_data;
         tx_ready <= 1'b0;
         tx_wait  <= 2'(rand_bits(2));
      end
      else if (tx_valid)
      begin
         if (held && tx_data != held_data)
         begin
            $display("[ERROR] %0t tx_data changed from %h to %h while waiting",
                     $time, held_data, tx_data);
            err_reply = err_reply + 1;
         end
         if (tx_wait == 2'd0)
            tx_ready <= 1'b1;
         else
            tx_wait <= tx_wait - 2'd1;
      end
      else if (held)
      begin
         $display("[ERROR] %0t tx_valid dropped before tx_ready", $time);
         err_reply = err_reply + 1;
      end
      held      <= tx_valid && !tx_ready;
      held_data <= tx_data;
   end

   // watchdog scaled by the number of cases, one extra slot for reset
   initial
   begin
      wait (cases_loaded);
      repeat ((n_cases + 1) * 400) @(posedge clk);
      $display("watchdog expired before all cases finished");
      $display("Verification failed");
      $finish;
   end

   initial
   begin
      int         tx_before;
      int         k;
      int         e;
      int         n;
      int         err_at;
      logic [4:0] c5;
      logic [15:0] c16;
      reset       = 1'b1;
      rx_data     = 8'h00;
      rx_active   = 1'b0;
      rx_valid    = 1'b0;
      rx_error    = 1'b0;
      device_addr = dev_addr;
      for (int i = 0; i < num_endp; i++)
      begin
         ep_ready[i] <= 1'b1;
         got_cnt[i]  = 0;
         end_cnt[i]  = 0;
         ok_cnt[i]   = 0;
      end
      load_cases();
      cases_loaded = 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      repeat (2) @(posedge clk);

      for (int t = 0; t < n_cases; t++)
      begin
         e = c_endp[t];
         for (int i = 0; i < num_endp; i++)
         begin
            got_cnt[i] = 0;
            end_cnt[i] = 0;
            ok_cnt[i]  = 0;
            ep_ready[i] <= !c_nrdy[t][i];
         end
         tx_before = tx_count;

         // token: pid, {endp[0], addr}, {crc5, endp[3:1]}
         c5 = token_crc5({4'(e), c_addr[t]});
         if (c_f5[t] != 0)
            c5[2] = ~c5[2];
         pkt[0] = {~c_tok[t], c_tok[t]};
         pkt[1] = {1'(e), c_addr[t]};
         pkt[2] = {c5, 3'(e >> 1)};
         send_packet(3, -1);

         // data packet with crc16 appended low byte first
         n      = c_len[t];
         c16    = 16'hffff;
         pkt[0] = c_dpid[t];
         for (int i = 0; i < n; i++)
         begin
            sent[i]    = 8'(rand_bits(8));
            pkt[i + 1] = sent[i];
            c16        = data_crc16(c16, sent[i]);
         end
         c16        = ~c16;
         pkt[n + 1] = c16[7:0];
         pkt[n + 2] = c16[15:8];
         if (c_f16[t] != 0)
            pkt[n + 1][0] = ~pkt[n + 1][0];
         err_at = (c_ferr[t] != 0) ? 2 : -1;   // after pid and one byte
         send_packet(n + 3, err_at);

         if (c_xrep[t] != 8'h00)
         begin
            k = 0;
            while (k < 200 && tx_count == tx_before)
            begin
               @(posedge clk);
               k++;
            end
            if (tx_count == tx_before)
            begin
               $display("case %0d: no handshake arrived within 200 cycles", t);
               err_other++;
            end
            repeat (2) @(posedge clk);
         end
         else
            repeat (30) @(posedge clk);   // quiet window

         // endpoints other than the addressed one stay silent
         for (int i = 0; i < num_endp; i++)
         begin
            if ((c_xdat[t] == 0 || i != e) && (got_cnt[i] != 0 || end_cnt[i] != 0))
            begin
               $display("[ERROR] %0t case %0d unexpected activity on endpoint %0d",
                        $time, t, i);
               err_data++;
            end
         end
         if (c_xdat[t] == 1)
         begin
            if (got_cnt[e] != n || end_cnt[e] != 1 || ok_cnt[e] != 1)
            begin
               $display("[ERROR] %0t case %0d ep%0d got %0d bytes, %0d ends, %0d ok",
                        $time, t, e, got_cnt[e], end_cnt[e], ok_cnt[e]);
               err_data++;
            end
            else
            begin
               for (int i = 0; i < n; i++)
                  if (got[e][i] != sent[i])
                  begin
                     $display("[ERROR] %0t case %0d byte %0d is %h, expected %h",
                              $time, t, i, got[e][i], sent[i]);
                     err_data++;
                  end
            end
         end
         if (c_xdat[t] == 2 && e < num_endp && (end_cnt[e] > 1 || ok_cnt[e] != 0))
         begin
            $display("[ERROR] %0t case %0d corrupt packet reported good", $time, t);
            err_data++;
         end

         if (c_xrep[t] == 8'h00 && tx_count != tx_before)
         begin
            $display("[ERROR] %0t case %0d unexpected handshake %h", $time, t, tx_last);
            err_reply++;
         end
         if (c_xrep[t] != 8'h00 && tx_count > tx_before + 1)
         begin
            $display("[ERROR] %0t case %0d %0d handshakes, expected one",
                     $time, t, tx_count - tx_before);
            err_reply++;
         end
         if (c_xrep[t] != 8'h00 && tx_count != tx_before && tx_last != c_xrep[t])
         begin
            $display("[ERROR] %0t case %0d handshake %h, expected %h",
                     $time, t, tx_last, c_xrep[t]);
            err_reply++;
         end
      end

      $display("cases %0d, data errors %0d, reply errors %0d, other errors %0d",
               n_cases, err_data, err_reply, err_other);
      if (err_data + err_reply + err_other == 0 && n_cases > 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* test/usb_sie_cases.txt */
# tok addr endp dpid len crc5_fault crc16_fault rx_err not_ready(ep2..ep0) exp_data exp_reply
# exp_data 0 silent, 1 payload with crc_ok, 2 crc_ok low; exp_reply 00 none, d2 ACK, 5a NAK
1 2a 1 c3 8 0 0 0 000 1 d2
1 2a 2 4b 5 0 0 0 000 1 d2
d 2a 0 c3 8 0 0 0 000 1 d2
1 2a 0 4b 16 0 0 0 000 1 d2
1 2a 1 c3 0 0 0 0 000 1 d2
1 15 1 c3 4 0 0 0 000 0 00
1 2a 1 c3 4 1 0 0 000 0 00
d 2a 1 c3 4 0 0 0 000 0 00
1 2a 3 c3 4 0 0 0 000 0 00
9 2a 0 c3 4 0 0 0 000 0 00
d 2a 0 4b 4 0 0 0 000 0 00
1 2a 1 d2 4 0 0 0 000 0 00
1 2a 1 c2 4 0 0 0 000 0 00
1 2a 2 c3 6 0 1 0 000 2 00
1 2a 0 c3 6 0 0 1 000 2 00
1 2a 1 c3 6 0 0 0 010 1 5a
d 2a 0 c3 8 0 0 0 001 1 5a
1 2a 2 4b 3 0 0 0 011 1 d2
1 2a 2 4b 7 0 0 0 100 1 5a
1 2a 1 c3 12 0 0 0 000 1 d2
1 7f 0 c3 2 0 0 0 000 0 00
1 2a 15 c3 2 0 0 0 000 0 00
1 2a 0 c3 1 0 0 0 000 1 d2

/* filelist.f */
design/usb_pkg.sv
design/usb_rx_decoder.sv
design/usb_crc16_check.sv
design/usb_transaction_ctrl.sv
design/usb_handshake_tx.sv
design/usb_sie_top.sv
test/usb_sie_tb.sv

/* Makefile */
# Verilator build and run for the USB SIE receive path

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= usb_sie_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
